// File: arcade_pkg.sv
package arcade_pkg;

	// ================================================
	// Common data widths
	// ================================================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] sample_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	// ================================================
	// Download targets
	// ================================================
	localparam dl_index_t DL_IDX_ROM  = 8'd0;
	localparam dl_index_t DL_IDX_MODE = 8'd1;
	localparam dl_index_t DL_IDX_DIP  = 8'd254;

	// Number of DIP switch bytes
	localparam int DIP_COUNT = 8;

	// Selected game as decoded from the mode byte
	// Code 2 and every unknown code fall to GAME_NONE
	typedef enum logic [1:0] {
		GAME_BAR    = 2'd0,
		GAME_LUMBER = 2'd1,
		GAME_NONE   = 2'd2,
		GAME_BAND   = 2'd3
	} game_t;

	// ================================================
	// Joystick word bit positions
	// ================================================
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_START  = 10;
	localparam int JOY_COIN   = 12;

endpackage

// File: download_ctrl.sv
`timescale 1ns/100ps

module download_ctrl import arcade_pkg::*; #(
	parameter int ROM_AW     = 16,
	parameter int RESET_HOLD = 65535
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  logic              dl_valid,
	input  dl_index_t         dl_index,
	input  dl_addr_t          dl_addr,
	input  byte_t             dl_data,
	output logic              dl_ready,
	output logic              rom_we,
	output logic [ROM_AW-1:0] rom_waddr,
	output byte_t             rom_wdata,
	output logic              dip_we,
	output logic [2:0]        dip_sel,
	output byte_t             dip_wdata,
	output game_t             game,
	output logic              rom_loaded,
	output logic              core_reset
);

	localparam int HOLD_W = (RESET_HOLD > 0) ? $clog2(RESET_HOLD + 1) : 1;

	logic              xfer;
	logic              rom_in_range;
	logic              dip_in_range;
	logic              rom_download;
	logic              reset_cause;
	logic              dl_active_d;
	logic              last_was_rom;
	logic [HOLD_W-1:0] hold_cnt;

	function automatic game_t decode_game(byte_t code);
		case (code)
			8'd0:    return GAME_BAR;
			8'd1:    return GAME_LUMBER;
			8'd3:    return GAME_BAND;
			default: return GAME_NONE;
		endcase
	endfunction

	// ================================================
	// Target decode
	// ================================================
	assign xfer         = dl_valid && dl_ready;
	assign rom_in_range = (dl_addr[$bits(dl_addr_t)-1:ROM_AW] == '0);
	assign dip_in_range = (dl_addr < dl_addr_t'(DIP_COUNT));

	// Bytes past the ROM end are dropped
	assign rom_we    = xfer && (dl_index == DL_IDX_ROM) && rom_in_range;
	assign rom_waddr = dl_addr[ROM_AW-1:0];
	assign rom_wdata = dl_data;

	assign dip_we    = xfer && (dl_index == DL_IDX_DIP) && dip_in_range;
	assign dip_sel   = dl_addr[2:0];
	assign dip_wdata = dl_data;

	// Game mode latch and end-of-download tracking
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_ready     <= 1'b0;
			game         <= GAME_BAR;
			dl_active_d  <= 1'b0;
			last_was_rom <= 1'b0;
			rom_loaded   <= 1'b0;
		end else begin
			dl_ready    <= 1'b1;
			dl_active_d <= dl_active;
			if (dl_active)
				last_was_rom <= (dl_index == DL_IDX_ROM);
			if (dl_active_d && !dl_active && last_was_rom)
				rom_loaded <= 1'b1;
			if (xfer && (dl_index == DL_IDX_MODE))
				game <= decode_game(dl_data);
		end
	end

	// ================================================
	// Core reset with hold time
	// ================================================
	assign rom_download = dl_active && (dl_index == DL_IDX_ROM);
	assign reset_cause  = reset || rom_download || !rom_loaded;

	// Hold counter reloads while any cause is present
	always_ff @(posedge clk_sys) begin
		if (reset_cause)
			hold_cnt <= HOLD_W'(RESET_HOLD);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		core_reset <= reset_cause || (hold_cnt != '0);
	end

	a_we_exclusive: assert property (@(posedge clk_sys) !(rom_we && dip_we));

	// Core stays in reset until a ROM image has been loaded
	a_reset_until_loaded: assert property (@(posedge clk_sys) disable iff (reset)
		!rom_loaded |-> core_reset);

endmodule

// File: cpu_rom.sv
`timescale 1ns/100ps

module cpu_rom import arcade_pkg::*; #(
	parameter int ROM_AW = 16
) (
	input  logic              clk_sys,
	input  logic              we,
	input  logic [ROM_AW-1:0] waddr,
	input  byte_t             wdata,
	input  logic [ROM_AW-1:0] raddr,
	output byte_t             rdata
);

	localparam int DEPTH = 1 << ROM_AW;

	byte_t mem [DEPTH];

	// Write side fed by the download stream
	always_ff @(posedge clk_sys) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read side for the core CPU
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

// File: dip_bank.sv
`timescale 1ns/100ps

module dip_bank import arcade_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       we,
	input  logic [2:0] sel,
	input  byte_t      wdata,
	output byte_t      dip0,
	output logic       service
);

	byte_t sw [DIP_COUNT];

	// Switches read as open (all ones) until downloaded
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < DIP_COUNT; i++)
				sw[i] <= '1;
		end else if (we) begin
			sw[sel] <= wdata;
		end
	end

	assign dip0    = sw[0];
	assign service = sw[1][0];

endmodule

// File: input_mapper.sv
`timescale 1ns/100ps

module input_mapper import arcade_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  game_t       game,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  byte_t       dip0,
	input  logic        service,
	output byte_t       input_0,
	output byte_t       input_1,
	output byte_t       input_2,
	output byte_t       input_3,
	output byte_t       input_4
);

	logic [15:0] joy_any;
	logic        fire_a_band;
	byte_t       port0_next;
	byte_t       port1_next;
	byte_t       port2_next;

	assign joy_any = joy1 | joy2;

	// Fire A shows up in the system port for the band game only
	assign fire_a_band = (game == GAME_BAND) && joy_any[JOY_FIRE_A];

	// ================================================
	// Active-low port layout per game
	// ================================================
	always_comb begin
		port0_next = ~{service, 2'b00, fire_a_band, joy2[JOY_START], joy1[JOY_START],
			1'b0, joy_any[JOY_COIN]};
		port1_next = '1;
		port2_next = '1;
		case (game)
			GAME_BAR: begin
				// Both players share the same controls
				port1_next = ~{3'b000, joy_any[JOY_FIRE_A], joy_any[JOY_UP],
					joy_any[JOY_DOWN], joy_any[JOY_LEFT], joy_any[JOY_RIGHT]};
				port2_next = port1_next;
			end
			GAME_LUMBER: begin
				port1_next = ~{2'b00, joy1[JOY_FIRE_A], joy1[JOY_FIRE_B], joy1[JOY_UP],
					joy1[JOY_DOWN], joy1[JOY_LEFT], joy1[JOY_RIGHT]};
				port2_next = ~{2'b00, joy2[JOY_FIRE_A], joy2[JOY_FIRE_B], joy2[JOY_UP],
					joy2[JOY_DOWN], joy2[JOY_LEFT], joy2[JOY_RIGHT]};
			end
			GAME_BAND: begin
				port1_next = ~{4'b0000, joy_any[JOY_DOWN], joy_any[JOY_UP],
					joy_any[JOY_RIGHT], joy_any[JOY_LEFT]};
				port2_next = ~{3'b000, joy_any[JOY_FIRE_A], joy_any[JOY_DOWN],
					joy_any[JOY_UP], joy_any[JOY_RIGHT], joy_any[JOY_LEFT]};
			end
			default: begin
				// Unknown game shows nothing pressed
				port0_next = '1;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			input_0 <= '1;
			input_1 <= '1;
			input_2 <= '1;
			input_3 <= '1;
		end else begin
			input_0 <= port0_next;
			input_1 <= port1_next;
			input_2 <= port2_next;
			input_3 <= dip0;
		end
	end

	// Unused port on all kept games
	assign input_4 = '1;

endmodule

// File: audio_mixer.sv
`timescale 1ns/100ps

module audio_mixer import arcade_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  game_t   game,
	input  logic    aud_valid_in,
	input  sample_t core_l,
	input  sample_t core_r,
	input  sample_t wave,
	output logic    aud_valid_out,
	output sample_t aud_l,
	output sample_t aud_r,
	output logic    aud_signed
);

	logic band;

	// Half the wave sample plus the unsigned core sample clamped to 16 bits signed
	function automatic sample_t mix_sat(sample_t core, sample_t wav);
		logic signed [17:0] half_wave;
		logic signed [17:0] sum;
		half_wave = {{3{wav[15]}}, wav[15:1]};
		sum       = half_wave + $signed({2'b00, core});
		if (sum > 18'sd32767)
			return 16'h7fff;
		else if (sum < -18'sd32768)
			return 16'h8000;
		else
			return sum[15:0];
	endfunction

	assign band = (game == GAME_BAND);

	always_ff @(posedge clk_sys) begin
		if (reset)
			aud_valid_out <= 1'b0;
		else
			aud_valid_out <= aud_valid_in;
	end

	// Sample registers load on every valid input even back to back
	always_ff @(posedge clk_sys) begin
		if (aud_valid_in) begin
			aud_l      <= band ? mix_sat(core_l, wave) : core_l;
			aud_r      <= band ? mix_sat(core_r, wave) : core_r;
			aud_signed <= band;
		end
	end

	a_no_valid_after_reset: assert property (@(posedge clk_sys) reset |=> !aud_valid_out);

endmodule

// File: arcade_core.sv
`timescale 1ns/100ps

module arcade_core import arcade_pkg::*; #(
	parameter int ROM_AW     = 16,
	parameter int RESET_HOLD = 65535
) (
	input  logic              clk_sys,
	input  logic              reset,
	// Host download stream
	input  logic              dl_active,
	input  logic              dl_valid,
	input  dl_index_t         dl_index,
	input  dl_addr_t          dl_addr,
	input  byte_t             dl_data,
	output logic              dl_ready,
	output logic              rom_loaded,
	output logic              core_reset,
	// Core CPU ROM read
	input  logic [ROM_AW-1:0] rom_addr,
	output byte_t             rom_data,
	// Controls and input ports
	input  logic [15:0]       joy1,
	input  logic [15:0]       joy2,
	output byte_t             input_0,
	output byte_t             input_1,
	output byte_t             input_2,
	output byte_t             input_3,
	output byte_t             input_4,
	// Audio
	input  logic              aud_valid_in,
	input  sample_t           core_l,
	input  sample_t           core_r,
	input  sample_t           wave,
	output logic              aud_valid_out,
	output sample_t           aud_l,
	output sample_t           aud_r,
	output logic              aud_signed
);

	logic              rom_we;
	logic [ROM_AW-1:0] rom_waddr;
	byte_t             rom_wdata;
	logic              dip_we;
	logic [2:0]        dip_sel;
	byte_t             dip_wdata;
	game_t             game;
	byte_t             dip0;
	logic              service;

	download_ctrl #(.ROM_AW(ROM_AW), .RESET_HOLD(RESET_HOLD)) u_download_ctrl (
		.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active), .dl_valid(dl_valid),
		.dl_index(dl_index), .dl_addr(dl_addr), .dl_data(dl_data), .dl_ready(dl_ready),
		.rom_we(rom_we), .rom_waddr(rom_waddr), .rom_wdata(rom_wdata),
		.dip_we(dip_we), .dip_sel(dip_sel), .dip_wdata(dip_wdata),
		.game(game), .rom_loaded(rom_loaded), .core_reset(core_reset)
	);

	cpu_rom #(.ROM_AW(ROM_AW)) u_cpu_rom (
		.clk_sys(clk_sys), .we(rom_we), .waddr(rom_waddr), .wdata(rom_wdata),
		.raddr(rom_addr), .rdata(rom_data)
	);

	dip_bank u_dip_bank (
		.clk_sys(clk_sys), .reset(reset), .we(dip_we), .sel(dip_sel), .wdata(dip_wdata),
		.dip0(dip0), .service(service)
	);

	input_mapper u_input_mapper (
		.clk_sys(clk_sys), .reset(reset), .game(game), .joy1(joy1), .joy2(joy2),
		.dip0(dip0), .service(service), .input_0(input_0), .input_1(input_1),
		.input_2(input_2), .input_3(input_3), .input_4(input_4)
	);

	audio_mixer u_audio_mixer (
		.clk_sys(clk_sys), .reset(reset), .game(game), .aud_valid_in(aud_valid_in),
		.core_l(core_l), .core_r(core_r), .wave(wave), .aud_valid_out(aud_valid_out),
		.aud_l(aud_l), .aud_r(aud_r), .aud_signed(aud_signed)
	);

endmodule

// File: tb_arcade_core.sv
`timescale 1ns/100ps

module tb_arcade_core import arcade_pkg::*; ();

	localparam int ROM_AW          = 10;
	localparam int RESET_HOLD      = 20;
	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 10;
	localparam int ROM_BYTES       = 1 << ROM_AW;
	localparam int HANDSHAKE_LIMIT = 50;
	localparam int JOY_N           = 8;
	localparam int AUD_N           = 7;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// Worst case has every ROM byte stalling once plus reset hold and readback
	localparam int TEST_CYCLES = RESET_CYCLES + 2 * (ROM_BYTES + 1) + RESET_HOLD + ROM_BYTES
		+ 2 * DIP_COUNT + 4 * (JOY_N + 4) + 2 * (AUD_N + 4) + 50;
	localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

	// {joy1, joy2}
	localparam logic [31:0] JOY_TABLE [JOY_N] = '{
		32'h0000_0000, 32'h0011_0000, 32'h0000_002a, 32'h1400_0400,
		32'h0004_1010, 32'hffff_ffff, 32'h002f_0010, 32'h1008_0005
	};

	// {core_l, core_r, wave}
	localparam logic [47:0] AUD_TABLE [AUD_N] = '{
		{16'h1000, 16'h0200, 16'h0400},
		{16'h7000, 16'h7f00, 16'h7ffe},
		{16'h0000, 16'h0001, 16'h8000},
		{16'h8000, 16'hffff, 16'h8000},
		{16'h0000, 16'h0010, 16'hffff},
		{16'h7fff, 16'h0000, 16'h0002},
		{16'h4000, 16'h1234, 16'hc001}
	};

	logic              clk_sys;
	logic              reset;
	logic              dl_active;
	logic              dl_valid;
	dl_index_t         dl_index;
	dl_addr_t          dl_addr;
	byte_t             dl_data;
	logic              dl_ready;
	logic              rom_loaded;
	logic              core_reset;
	logic [ROM_AW-1:0] rom_addr;
	byte_t             rom_data;
	logic [15:0]       joy1;
	logic [15:0]       joy2;
	byte_t             input_0;
	byte_t             input_1;
	byte_t             input_2;
	byte_t             input_3;
	byte_t             input_4;
	logic              aud_valid_in;
	sample_t           core_l;
	sample_t           core_r;
	sample_t           wave;
	logic              aud_valid_out;
	sample_t           aud_l;
	sample_t           aud_r;
	logic              aud_signed;

	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] lfsr_state;
	byte_t       rom_exp [ROM_BYTES];
	byte_t       dip_exp [DIP_COUNT];

	arcade_core #(.ROM_AW(ROM_AW), .RESET_HOLD(RESET_HOLD)) DUT (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ================================================
	// Helpers
	// ================================================
	function automatic logic [7:0] random_bits(int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
			else
				lfsr_state = lfsr_state >> 1;
			r = {r[6:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual,
				expected);
		end
	endtask

	// Active-low port byte for input_0 to input_2
	function automatic byte_t port_model(int port, byte_t code, logic [15:0] j1,
		logic [15:0] j2, logic svc);
		logic [15:0] a;
		byte_t       p;
		a = j1 | j2;
		p = 8'h00;
		if (code != 8'd0 && code != 8'd1 && code != 8'd3)
			return 8'hff;
		if (port == 0)
			p = {svc, 2'b00, (code == 8'd3) && a[JOY_FIRE_A], j2[JOY_START], j1[JOY_START],
				1'b0, a[JOY_COIN]};
		else if (code == 8'd0)
			p = {3'b000, a[JOY_FIRE_A], a[JOY_UP], a[JOY_DOWN], a[JOY_LEFT], a[JOY_RIGHT]};
		else if (code == 8'd1 && port == 1)
			p = {2'b00, j1[JOY_FIRE_A], j1[JOY_FIRE_B], j1[JOY_UP], j1[JOY_DOWN],
				j1[JOY_LEFT], j1[JOY_RIGHT]};
		else if (code == 8'd1)
			p = {2'b00, j2[JOY_FIRE_A], j2[JOY_FIRE_B], j2[JOY_UP], j2[JOY_DOWN],
				j2[JOY_LEFT], j2[JOY_RIGHT]};
		else if (port == 1)
			p = {4'b0000, a[JOY_DOWN], a[JOY_UP], a[JOY_RIGHT], a[JOY_LEFT]};
		else
			p = {3'b000, a[JOY_FIRE_A], a[JOY_DOWN], a[JOY_UP], a[JOY_RIGHT], a[JOY_LEFT]};
		return ~p;
	endfunction

	// Band game mix of the halved wave and the unsigned core sample with clamping
	function automatic logic [15:0] mix_model(logic [15:0] core, logic [15:0] wav);
		int sum;
		sum = (int'($signed(wav)) >>> 1) + int'(core);
		if (sum > 32767)
			return 16'h7fff;
		if (sum < -32768)
			return 16'h8000;
		return 16'(sum);
	endfunction

	task automatic send_byte(dl_index_t idx, int addr, byte_t data);
		int wait_cycles;
		wait_cycles = 0;
		dl_valid = 1'b1;
		dl_index = idx;
		dl_addr  = dl_addr_t'(addr);
		dl_data  = data;
		// Ready seen at the falling edge holds through the next rising edge
		while (!dl_ready && wait_cycles < HANDSHAKE_LIMIT) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		if (!dl_ready) begin
			errors++;
			$display("Download byte at index %0d address %0d was never accepted", idx, addr);
		end
		@(negedge clk_sys);
		dl_valid = 1'b0;
	endtask

	task automatic set_mode(byte_t code);
		dl_active = 1'b1;
		send_byte(DL_IDX_MODE, 0, code);
		dl_active = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_ports(byte_t code, int row);
		check_value($sformatf("input_0 mode %0d row %0d", code, row), 32'(input_0),
			32'(port_model(0, code, joy1, joy2, dip_exp[1][0])));
		check_value($sformatf("input_1 mode %0d row %0d", code, row), 32'(input_1),
			32'(port_model(1, code, joy1, joy2, dip_exp[1][0])));
		check_value($sformatf("input_2 mode %0d row %0d", code, row), 32'(input_2),
			32'(port_model(2, code, joy1, joy2, dip_exp[1][0])));
		check_value("input_3", 32'(input_3), 32'(dip_exp[0]));
		check_value("input_4", 32'(input_4), 32'hff);
	endtask

	// Samples go in back to back and each is checked a cycle later
	task automatic run_audio(byte_t code);
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		set_mode(code);
		for (int i = 0; i < AUD_N; i++) begin
			aud_valid_in = 1'b1;
			core_l       = AUD_TABLE[i][47:32];
			core_r       = AUD_TABLE[i][31:16];
			wave         = AUD_TABLE[i][15:0];
			@(negedge clk_sys);
			exp_l = (code == 8'd3) ? mix_model(core_l, wave) : core_l;
			exp_r = (code == 8'd3) ? mix_model(core_r, wave) : core_r;
			check_value("aud_valid_out", 32'(aud_valid_out), 32'd1);
			check_value($sformatf("aud_l mode %0d row %0d", code, i), 32'(aud_l), 32'(exp_l));
			check_value($sformatf("aud_r mode %0d row %0d", code, i), 32'(aud_r), 32'(exp_r));
			check_value("aud_signed", 32'(aud_signed), 32'(code == 8'd3));
		end
		aud_valid_in = 1'b0;
		@(negedge clk_sys);
		check_value("aud_valid_out idle", 32'(aud_valid_out), 32'd0);
	endtask

	// ================================================
	// Test sequence
	// ================================================
	initial begin
		lfsr_state   = 32'h5a6e;
		errors       = 0;
		checks       = 0;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_valid     = 1'b0;
		dl_index     = DL_IDX_ROM;
		dl_addr      = '0;
		dl_data      = '0;
		rom_addr     = '0;
		joy1         = '0;
		joy2         = '0;
		aud_valid_in = 1'b0;
		core_l       = '0;
		core_r       = '0;
		wave         = '0;

		repeat (RESET_CYCLES) begin
			@(negedge clk_sys);
			check_value("dl_ready in reset", 32'(dl_ready), 32'd0);
			check_value("core_reset in reset", 32'(core_reset), 32'd1);
		end
		reset = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("dl_ready", 32'(dl_ready), 32'd1);
		check_value("core_reset before ROM", 32'(core_reset), 32'd1);
		check_value("rom_loaded before ROM", 32'(rom_loaded), 32'd0);

		// ROM image with random stalls and then one byte past the end
		dl_active = 1'b1;
		dl_index  = DL_IDX_ROM;
		for (int a = 0; a < ROM_BYTES; a++) begin
			rom_exp[a] = random_bits(8);
			if (random_bits(2) == 8'd3)
				@(negedge clk_sys);
			send_byte(DL_IDX_ROM, a, rom_exp[a]);
		end
		send_byte(DL_IDX_ROM, ROM_BYTES, ~rom_exp[0]);
		check_value("core_reset in download", 32'(core_reset), 32'd1);
		dl_active = 1'b0;
		cycles = 0;
		while (!rom_loaded && cycles < HANDSHAKE_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_value("rom_loaded delay", 32'(cycles), 32'd1);
		check_value("core_reset at load", 32'(core_reset), 32'd1);
		cycles = 0;
		while (core_reset && cycles < RESET_HOLD + 10) begin
			@(negedge clk_sys);
			cycles++;
		end
		check_value("core_reset hold cycles", 32'(cycles), 32'(RESET_HOLD + 1));

		for (int a = 0; a < ROM_BYTES; a++) begin
			@(negedge clk_sys);
			check_value($sformatf("rom_data[%0d]", a), 32'(rom_data), 32'(rom_exp[a]));
			rom_addr = ROM_AW'(a + 1);
		end

		// DIP bank
		dl_active = 1'b1;
		dl_index  = DL_IDX_DIP;
		for (int a = 0; a < DIP_COUNT; a++) begin
			dip_exp[a] = random_bits(8);
			send_byte(DL_IDX_DIP, a, dip_exp[a]);
		end
		dl_active = 1'b0;
		@(negedge clk_sys);
		check_value("input_3 after DIP", 32'(input_3), 32'(dip_exp[0]));
		check_value("service bit", 32'(input_0[7]), 32'(!dip_exp[1][0]));

		// Input ports for each mode where mode 2 falls to the unknown game
		for (int m = 0; m < 4; m++) begin
			set_mode(8'(m));
			for (int r = 0; r < JOY_N; r++) begin
				joy1 = JOY_TABLE[r][31:16];
				joy2 = JOY_TABLE[r][15:0];
				@(negedge clk_sys);
				check_ports(8'(m), r);
			end
		end

		run_audio(8'd3);
		run_audio(8'd0);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired after %0d ns, the test sequence did not finish",
			WATCHDOG_TIME);
		$display("Test failed");
		$finish;
	end

endmodule

// File: arcade_core.f
arcade_pkg.sv
download_ctrl.sv
cpu_rom.sv
dip_bank.sv
input_mapper.sv
audio_mixer.sv
arcade_core.sv
tb_arcade_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_arcade_core
FILELIST  = arcade_core.f
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
